// File: wrb_pkg.sv
/* Write response bank definitions */

`default_nettype none

package wrb_pkg;

  // Bank sizes
  localparam int NumIds        = 4;
  localparam int IdWidth       = 2;
  localparam int BankCapacity  = 8;
  localparam int BankAddrWidth = 3;
  localparam int ContentWidth  = 8;
  localparam int CountWidth    = 4;

  typedef logic [IdWidth-1:0]       id_t;
  typedef logic [BankAddrWidth-1:0] bank_addr_t;
  typedef logic [ContentWidth-1:0]  content_t;
  typedef logic [CountWidth-1:0]    count_t;
  typedef logic [BankCapacity-1:0]  slot_mask_t;

  typedef struct packed {
    id_t      id;
    content_t content;
  } write_resp_t;

  // Output stage states
  typedef enum logic [0:0] {
    OutEmpty,
    OutPresent
  } out_state_t;

endpackage

`default_nettype wire

// File: wrb_mem_if.sv
/* Storage array port bundle */

`timescale 1ns/10ps
`default_nettype none

interface wrb_mem_if #(
  parameter type payload_t = logic,
  parameter int  Depth     = 8
);

  localparam int AddrWidth = (Depth > 1) ? $clog2(Depth) : 1;

  // Write port
  logic                 we;
  logic [AddrWidth-1:0] waddr;
  payload_t             wdata;

  // Two read ports
  logic [AddrWidth-1:0] raddr_a;
  payload_t             rdata_a;
  logic [AddrWidth-1:0] raddr_b;
  payload_t             rdata_b;

  modport mem (input we, waddr, wdata, raddr_a, raddr_b, output rdata_a, rdata_b);

  modport writer (output we, waddr, wdata, raddr_a, raddr_b, input rdata_a, rdata_b);

  modport reader (output raddr_a, input rdata_a);

endinterface

`default_nettype wire

// File: wrb_mem.sv
/* Flop storage array */

`timescale 1ns/10ps
`default_nettype none

module wrb_mem #(
  parameter type payload_t = logic,
  parameter int  Depth     = 8
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  wrb_mem_if.mem    mem_if
);

  payload_t mem_q [Depth];

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Depth; i++) begin
        mem_q[i] <= '0;
      end
    end else if (mem_if.we) begin
      mem_q[mem_if.waddr] <= mem_if.wdata;
    end
  end

  ////////////////////////////////////////
  // Read ports without latency
  ////////////////////////////////////////

  assign mem_if.rdata_a = mem_q[mem_if.raddr_a];
  assign mem_if.rdata_b = mem_q[mem_if.raddr_b];

endmodule

`default_nettype wire

// File: wrb_slot_alloc.sv
/* Slot allocator */

`timescale 1ns/10ps
`default_nettype none

module wrb_slot_alloc (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                i_alloc,
  input  wire wrb_pkg::slot_mask_t i_free_onehot,
  output wrb_pkg::bank_addr_t      o_free_addr,
  output logic                     o_not_full
);

  import wrb_pkg::*;

  // One bit per slot, set while the slot is reserved or holds a response
  slot_mask_t used_q;
  slot_mask_t used_d;

  ////////////////////////////////////////
  // Lowest free slot
  ////////////////////////////////////////

  // Scan from the top so that the lowest clear bit wins
  always_comb begin : find_free
    o_free_addr = '0;
    for (int i = BankCapacity - 1; i >= 0; i--) begin
      if (!used_q[i]) begin
        o_free_addr = bank_addr_t'(i);
      end
    end
  end

  assign o_not_full = ~&used_q;

  ////////////////////////////////////////
  // Valid bit update
  ////////////////////////////////////////

  // Allocated and freed slots never coincide
  always_comb begin : next_used
    used_d = used_q & ~i_free_onehot;
    if (i_alloc) begin
      used_d[o_free_addr] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      used_q <= '0;
    end else begin
      used_q <= used_d;
    end
  end

endmodule

`default_nettype wire

// File: wrb_id_counters.sv
/* Per-identifier entry counters */

`timescale 1ns/10ps
`default_nettype none

module wrb_id_counters (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  input  wire logic          i_res_fire,
  input  wire wrb_pkg::id_t  i_res_id,
  input  wire logic          i_in_fire,
  input  wire wrb_pkg::id_t  i_in_id,
  input  wire logic          i_out_fire,
  input  wire wrb_pkg::id_t  i_out_id,
  output wrb_pkg::count_t    o_rsrv_cnt   [wrb_pkg::NumIds],
  output wrb_pkg::count_t    o_stored_cnt [wrb_pkg::NumIds]
);

  import wrb_pkg::*;

  count_t rsrv_q   [NumIds];
  count_t stored_q [NumIds];

  ////////////////////////////////////////
  // Count update
  ////////////////////////////////////////

  // All three events may hit the same identifier in one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumIds; i++) begin
        rsrv_q[i]   <= '0;
        stored_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NumIds; i++) begin
        rsrv_q[i] <= rsrv_q[i]
                     + count_t'(i_res_fire && (i_res_id == id_t'(i)))
                     - count_t'(i_in_fire && (i_in_id == id_t'(i)));
        stored_q[i] <= stored_q[i]
                       + count_t'(i_in_fire && (i_in_id == id_t'(i)))
                       - count_t'(i_out_fire && (i_out_id == id_t'(i)));
      end
    end
  end

  assign o_rsrv_cnt   = rsrv_q;
  assign o_stored_cnt = stored_q;

endmodule

`default_nettype wire

// File: wrb_queue_ptrs.sv
/* Per-identifier queue pointers */

`timescale 1ns/10ps
`default_nettype none

module wrb_queue_ptrs (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 i_res_fire,
  input  wire wrb_pkg::id_t         i_res_id,
  input  wire wrb_pkg::bank_addr_t  i_new_addr,
  input  wire logic                 i_in_fire,
  input  wire wrb_pkg::write_resp_t i_in_data,
  input  wire logic                 i_out_fire,
  input  wire wrb_pkg::id_t         i_out_id,
  input  wire wrb_pkg::count_t      i_rsrv_cnt   [wrb_pkg::NumIds],
  input  wire wrb_pkg::count_t      i_stored_cnt [wrb_pkg::NumIds],
  output wrb_pkg::bank_addr_t       o_heads      [wrb_pkg::NumIds],
  wrb_mem_if.writer                 msg_if,
  wrb_mem_if.writer                 link_if
);

  import wrb_pkg::*;

  // Head is the oldest stored slot, fill the oldest unfilled one, tail the newest
  bank_addr_t heads_q [NumIds];
  bank_addr_t heads_d [NumIds];
  bank_addr_t fills_q [NumIds];
  bank_addr_t fills_d [NumIds];
  bank_addr_t tails_q [NumIds];
  bank_addr_t tails_d [NumIds];

  logic [NumIds-1:0] empty;

  // A queue drained by this cycle's output starts over on a reservation
  always_comb begin : calc_empty
    count_t left_after_out;
    for (int i = 0; i < NumIds; i++) begin
      left_after_out = i_stored_cnt[i] - count_t'(i_out_fire && (i_out_id == id_t'(i)));
      empty[i] = (i_rsrv_cnt[i] == '0) && (left_after_out == '0);
    end
  end

  ////////////////////////////////////////
  // Pointer update
  ////////////////////////////////////////

  always_comb begin : next_ptrs
    logic   res_hit;
    logic   in_hit;
    logic   out_hit;
    count_t unfilled_after_in;
    for (int i = 0; i < NumIds; i++) begin
      res_hit = i_res_fire && (i_res_id == id_t'(i));
      in_hit  = i_in_fire && (i_in_data.id == id_t'(i));
      out_hit = i_out_fire && (i_out_id == id_t'(i));
      unfilled_after_in = i_rsrv_cnt[i] - count_t'(in_hit);

      heads_d[i] = out_hit ? link_if.rdata_b : heads_q[i];
      fills_d[i] = in_hit ? link_if.rdata_a : fills_q[i];
      tails_d[i] = tails_q[i];

      if (res_hit) begin
        tails_d[i] = i_new_addr;
        if (empty[i]) begin
          heads_d[i] = i_new_addr;
        end
        if (unfilled_after_in == '0) begin
          fills_d[i] = i_new_addr;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumIds; i++) begin
        heads_q[i] <= '0;
        fills_q[i] <= '0;
        tails_q[i] <= '0;
      end
    end else begin
      heads_q <= heads_d;
      fills_q <= fills_d;
      tails_q <= tails_d;
    end
  end

  ////////////////////////////////////////
  // Memory accesses
  ////////////////////////////////////////

  assign msg_if.we    = i_in_fire;
  assign msg_if.waddr = fills_q[i_in_data.id];
  assign msg_if.wdata = i_in_data.content;

  // Chain the new slot behind the current tail
  assign link_if.we      = i_res_fire && !empty[i_res_id];
  assign link_if.waddr   = tails_q[i_res_id];
  assign link_if.wdata   = i_new_addr;
  assign link_if.raddr_a = fills_q[i_in_data.id];
  assign link_if.raddr_b = heads_q[i_out_id];

  assign o_heads = heads_q;

endmodule

`default_nettype wire

// File: wrb_out_fsm.sv
/* Release arbiter and output stage */

`timescale 1ns/10ps
`default_nettype none

module wrb_out_fsm (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire wrb_pkg::count_t     i_stored_cnt [wrb_pkg::NumIds],
  input  wire wrb_pkg::bank_addr_t i_heads      [wrb_pkg::NumIds],
  input  wire wrb_pkg::slot_mask_t i_release_en,
  input  wire logic                i_out_ready,
  output logic                     o_out_valid,
  output wrb_pkg::write_resp_t     o_out_data,
  output logic                     o_out_fire,
  output wrb_pkg::id_t             o_out_id,
  output wrb_pkg::slot_mask_t      o_rel_addr_onehot,
  wrb_mem_if.reader                msg_if
);

  import wrb_pkg::*;

  out_state_t        state_q;
  out_state_t        state_d;
  logic [NumIds-1:0] eligible;
  id_t               pick_id;
  logic              load;
  bank_addr_t        out_addr_q;
  write_resp_t       out_data_q;

  ////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////

  // Queue has a stored head whose release bit is set
  always_comb begin : calc_eligible
    for (int i = 0; i < NumIds; i++) begin
      eligible[i] = (i_stored_cnt[i] != '0) && i_release_en[i_heads[i]];
    end
  end

  // Lowest identifier wins
  always_comb begin : pick_lowest
    pick_id = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        pick_id = id_t'(i);
      end
    end
  end

  assign msg_if.raddr_a = i_heads[pick_id];
  assign load = (state_q == OutEmpty) && (|eligible);

  ////////////////////////////////////////
  // Output FSM
  ////////////////////////////////////////

  always_comb begin : next_state
    state_d = state_q;
    case (state_q)
      OutEmpty:   if (load) state_d = OutPresent;
      OutPresent: if (i_out_ready) state_d = OutEmpty;
      default:    state_d = OutEmpty;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= OutEmpty;
    end else begin
      state_q <= state_d;
    end
  end

  // Presented response is held under back-pressure
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_addr_q <= '0;
      out_data_q <= '0;
    end else if (load) begin
      out_addr_q         <= i_heads[pick_id];
      out_data_q.id      <= pick_id;
      out_data_q.content <= msg_if.rdata_a;
    end
  end

  assign o_out_valid = (state_q == OutPresent);
  assign o_out_data  = out_data_q;
  assign o_out_fire  = o_out_valid && i_out_ready;
  assign o_out_id    = out_data_q.id;

  always_comb begin : rel_onehot
    o_rel_addr_onehot = '0;
    if (o_out_fire) begin
      o_rel_addr_onehot[out_addr_q] = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: wrb_bank.sv
/* Write response bank top */

`timescale 1ns/10ps
`default_nettype none

module wrb_bank (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,

  // Reservation
  input  wire logic                 i_res_valid,
  input  wire wrb_pkg::id_t         i_res_id,
  output logic                      o_res_ready,
  output wrb_pkg::bank_addr_t       o_res_addr,

  // Incoming responses
  input  wire logic                 i_in_valid,
  input  wire wrb_pkg::write_resp_t i_in_data,
  output logic                      o_in_ready,

  // Release enables, multi-hot
  input  wire wrb_pkg::slot_mask_t  i_release_en,

  // Outgoing responses
  output logic                      o_out_valid,
  output wrb_pkg::write_resp_t      o_out_data,
  input  wire logic                 i_out_ready,
  output wrb_pkg::slot_mask_t       o_rel_addr_onehot
);

  import wrb_pkg::*;

  logic       res_fire;
  logic       in_fire;
  logic       out_fire;
  id_t        out_id;
  count_t     rsrv_cnt   [NumIds];
  count_t     stored_cnt [NumIds];
  bank_addr_t heads      [NumIds];

  wrb_mem_if #(.payload_t(content_t),   .Depth(BankCapacity)) msg_if ();
  wrb_mem_if #(.payload_t(bank_addr_t), .Depth(BankCapacity)) link_if ();

  ////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////

  assign res_fire   = i_res_valid && o_res_ready;
  assign o_in_ready = (rsrv_cnt[i_in_data.id] != '0);
  assign in_fire    = i_in_valid && o_in_ready;

  // Message read port B is spare
  assign msg_if.raddr_b = '0;

  ////////////////////////////////////////
  // Submodules
  ////////////////////////////////////////

  wrb_slot_alloc i_slot_alloc (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .i_alloc       (res_fire),
    .i_free_onehot (o_rel_addr_onehot),
    .o_free_addr   (o_res_addr),
    .o_not_full    (o_res_ready)
  );

  wrb_id_counters i_id_counters (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_res_fire   (res_fire),
    .i_res_id     (i_res_id),
    .i_in_fire    (in_fire),
    .i_in_id      (i_in_data.id),
    .i_out_fire   (out_fire),
    .i_out_id     (out_id),
    .o_rsrv_cnt   (rsrv_cnt),
    .o_stored_cnt (stored_cnt)
  );

  wrb_queue_ptrs i_queue_ptrs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_res_fire   (res_fire),
    .i_res_id     (i_res_id),
    .i_new_addr   (o_res_addr),
    .i_in_fire    (in_fire),
    .i_in_data    (i_in_data),
    .i_out_fire   (out_fire),
    .i_out_id     (out_id),
    .i_rsrv_cnt   (rsrv_cnt),
    .i_stored_cnt (stored_cnt),
    .o_heads      (heads),
    .msg_if       (msg_if.writer),
    .link_if      (link_if.writer)
  );

  wrb_out_fsm i_out_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_stored_cnt      (stored_cnt),
    .i_heads           (heads),
    .i_release_en      (i_release_en),
    .i_out_ready       (i_out_ready),
    .o_out_valid       (o_out_valid),
    .o_out_data        (o_out_data),
    .o_out_fire        (out_fire),
    .o_out_id          (out_id),
    .o_rel_addr_onehot (o_rel_addr_onehot),
    .msg_if            (msg_if.reader)
  );

  wrb_mem #(.payload_t(content_t), .Depth(BankCapacity)) i_msg_mem (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .mem_if (msg_if.mem)
  );

  wrb_mem #(.payload_t(bank_addr_t), .Depth(BankCapacity)) i_link_mem (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .mem_if (link_if.mem)
  );

endmodule

`default_nettype wire

// File: tb_wrb_tasks.svh
/* Testbench drive, compare and test tasks */

`ifndef TB_WRB_TASKS_SVH
`define TB_WRB_TASKS_SVH

////////////////////////////////////////
// Compare tasks
////////////////////////////////////////

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("[ERROR] %0t: %s is %b, expected %b", $time, name, got, exp);
    fail_run();
  end
endtask

task automatic check_addr(input string name, input bank_addr_t got, input bank_addr_t exp);
  if (got !== exp) begin
    $display("[ERROR] %0t: %s is %0d, expected %0d", $time, name, got, exp);
    fail_run();
  end
endtask

task automatic check_mask(input string name, input slot_mask_t got, input slot_mask_t exp);
  if (got !== exp) begin
    $display("[ERROR] %0t: %s is %b, expected %b", $time, name, got, exp);
    fail_run();
  end
endtask

task automatic check_resp(input string name, input write_resp_t got, input write_resp_t exp);
  if (got !== exp) begin
    $display("[ERROR] %0t: %s is id %0d content %h, expected id %0d content %h",
             $time, name, got.id, got.content, exp.id, exp.content);
    fail_run();
  end
endtask

////////////////////////////////////////
// Drive tasks
////////////////////////////////////////

// Inputs change 1 ns after the rising edge, outputs are sampled at the falling edge
task automatic next_drive();
  @(posedge clk_i);
  #1;
endtask

task automatic reserve_slot(input id_t id, input bank_addr_t exp_addr);
  res_valid = 1'b1;
  res_id    = id;
  @(negedge clk_i);
  check_bit("o_res_ready", res_ready, 1'b1);
  check_addr("o_res_addr", res_addr, exp_addr);
  next_drive();
  res_valid = 1'b0;
endtask

task automatic send_content(input id_t id, input content_t content);
  in_valid        = 1'b1;
  in_data.id      = id;
  in_data.content = content;
  @(negedge clk_i);
  check_bit("o_in_ready", in_ready, 1'b1);
  next_drive();
  in_valid = 1'b0;
endtask

// Returns at the drive point after o_out_valid was seen high
task automatic wait_out_valid();
  logic seen;
  seen = 1'b0;
  while (!seen) begin
    @(negedge clk_i);
    seen = out_valid;
    next_drive();
  end
endtask

// Accepts the presented response and checks the freed slot
task automatic take_out(input write_resp_t exp_resp, input bank_addr_t exp_slot,
                        output slot_mask_t freed);
  slot_mask_t exp_mask;
  exp_mask           = '0;
  exp_mask[exp_slot] = 1'b1;
  out_ready          = 1'b1;
  @(negedge clk_i);
  check_bit("o_out_valid", out_valid, 1'b1);
  check_resp("o_out_data", out_data, exp_resp);
  check_mask("o_rel_addr_onehot", rel_onehot, exp_mask);
  freed = rel_onehot;
  next_drive();
  out_ready = 1'b0;
endtask

function automatic write_resp_t make_resp(input id_t id, input content_t content);
  write_resp_t resp;
  resp.id      = id;
  resp.content = content;
  return resp;
endfunction

////////////////////////////////////////
// Directed tests
////////////////////////////////////////

task automatic check_after_reset();
  @(negedge clk_i);
  check_bit("o_out_valid", out_valid, 1'b0);
  check_bit("o_res_ready", res_ready, 1'b1);
  check_addr("o_res_addr", res_addr, '0);
  check_mask("o_rel_addr_onehot", rel_onehot, '0);
  next_drive();
  // No identifier holds a reservation yet
  for (int i = 0; i < NumIds; i++) begin
    in_data.id = id_t'(i);
    @(negedge clk_i);
    check_bit("o_in_ready", in_ready, 1'b0);
    next_drive();
  end
endtask

task automatic run_in_order_burst();
  content_t   c [3];
  slot_mask_t freed;
  for (int i = 0; i < 3; i++) begin
    reserve_slot(id_t'(1), bank_addr_t'(i));
  end
  for (int i = 0; i < 3; i++) begin
    c[i] = content_t'($random(seed));
    send_content(id_t'(1), c[i]);
  end
  release_en = '1;
  for (int i = 0; i < 3; i++) begin
    wait_out_valid();
    take_out(make_resp(id_t'(1), c[i]), bank_addr_t'(i), freed);
  end
  release_en = '0;
endtask

task automatic hold_until_release();
  content_t   c;
  slot_mask_t freed;
  c = content_t'($random(seed));
  reserve_slot(id_t'(2), bank_addr_t'(0));
  send_content(id_t'(2), c);
  repeat (20) begin
    @(negedge clk_i);
    check_bit("o_out_valid", out_valid, 1'b0);
    next_drive();
  end
  // Valid must rise on the edge right after the bit is set
  release_en[0] = 1'b1;
  @(negedge clk_i);
  check_bit("o_out_valid", out_valid, 1'b0);
  next_drive();
  @(negedge clk_i);
  check_bit("o_out_valid", out_valid, 1'b1);
  next_drive();
  take_out(make_resp(id_t'(2), c), bank_addr_t'(0), freed);
  release_en = '0;
endtask

task automatic arbitrate_lowest_id();
  content_t   c3;
  content_t   c0;
  slot_mask_t freed;
  c3 = content_t'($random(seed));
  c0 = content_t'($random(seed));
  reserve_slot(id_t'(3), bank_addr_t'(0));
  reserve_slot(id_t'(0), bank_addr_t'(1));
  send_content(id_t'(3), c3);
  send_content(id_t'(0), c0);
  release_en = '1;
  wait_out_valid();
  take_out(make_resp(id_t'(0), c0), bank_addr_t'(1), freed);
  wait_out_valid();
  take_out(make_resp(id_t'(3), c3), bank_addr_t'(0), freed);
  // Identifier 2 has nothing reserved
  in_valid        = 1'b1;
  in_data.id      = id_t'(2);
  in_data.content = content_t'($random(seed));
  @(negedge clk_i);
  check_bit("o_in_ready", in_ready, 1'b0);
  next_drive();
  in_valid = 1'b0;
  repeat (4) begin
    @(negedge clk_i);
    check_bit("o_out_valid", out_valid, 1'b0);
    next_drive();
  end
  release_en = '0;
endtask

task automatic fill_whole_bank();
  content_t   c;
  slot_mask_t freed;
  bank_addr_t freed_addr;
  for (int i = 0; i < BankCapacity; i++) begin
    reserve_slot(id_t'(i % NumIds), bank_addr_t'(i));
  end
  @(negedge clk_i);
  check_bit("o_res_ready", res_ready, 1'b0);
  next_drive();
  c = content_t'($random(seed));
  send_content(id_t'(0), c);
  release_en = '1;
  wait_out_valid();
  take_out(make_resp(id_t'(0), c), bank_addr_t'(0), freed);
  freed_addr = '0;
  for (int i = 0; i < BankCapacity; i++) begin
    if (freed[i]) begin
      freed_addr = bank_addr_t'(i);
    end
  end
  @(negedge clk_i);
  check_bit("o_res_ready", res_ready, 1'b1);
  check_addr("o_res_addr", res_addr, freed_addr);
  next_drive();
  release_en = '0;
endtask

task automatic stall_output();
  content_t   c;
  slot_mask_t freed;
  c = content_t'($random(seed));
  // Identifier 1 still owns slots 1 and 5 from the full bank
  send_content(id_t'(1), c);
  release_en[1] = 1'b1;
  wait_out_valid();
  repeat (10) begin
    @(negedge clk_i);
    check_bit("o_out_valid", out_valid, 1'b1);
    check_resp("o_out_data", out_data, make_resp(id_t'(1), c));
    check_mask("o_rel_addr_onehot", rel_onehot, '0);
    next_drive();
  end
  take_out(make_resp(id_t'(1), c), bank_addr_t'(1), freed);
  @(negedge clk_i);
  check_bit("o_out_valid", out_valid, 1'b0);
  next_drive();
  release_en = '0;
endtask

`endif

// File: tb_wrb_bank.sv
/* Write response bank testbench */

`timescale 1ns/10ps
`default_nettype none

module tb_wrb_bank;

  import wrb_pkg::*;

  localparam int TimeoutCycles = 2000;

  logic        clk_i;
  logic        rst_ni;
  logic        res_valid;
  id_t         res_id;
  logic        res_ready;
  bank_addr_t  res_addr;
  logic        in_valid;
  write_resp_t in_data;
  logic        in_ready;
  slot_mask_t  release_en;
  logic        out_valid;
  write_resp_t out_data;
  logic        out_ready;
  slot_mask_t  rel_onehot;

  integer seed;
  int     cycle_cnt;

  wrb_bank i_dut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_res_valid       (res_valid),
    .i_res_id          (res_id),
    .o_res_ready       (res_ready),
    .o_res_addr        (res_addr),
    .i_in_valid        (in_valid),
    .i_in_data         (in_data),
    .o_in_ready        (in_ready),
    .i_release_en      (release_en),
    .o_out_valid       (out_valid),
    .o_out_data        (out_data),
    .i_out_ready       (out_ready),
    .o_rel_addr_onehot (rel_onehot)
  );

  // Ends the run at the first failure
  task automatic fail_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped after a failure");
  endtask

  `include "tb_wrb_tasks.svh"

  ////////////////////////////////////////
  // Clock and timeout
  ////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    cycle_cnt = 0;
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      fail_run();
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    seed       = 80972;
    rst_ni     = 1'b0;
    res_valid  = 1'b0;
    res_id     = '0;
    in_valid   = 1'b0;
    in_data    = '0;
    release_en = '0;
    out_ready  = 1'b0;

    // Two cycles of reset, then release it at the drive point
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    check_after_reset();
    run_in_order_burst();
    hold_until_release();
    arbitrate_lowest_id();
    fill_whole_bank();
    stall_output();

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
wrb_pkg.sv
wrb_mem_if.sv
wrb_mem.sv
wrb_slot_alloc.sv
wrb_id_counters.sv
wrb_queue_ptrs.sv
wrb_out_fsm.sv
wrb_bank.sv
tb_wrb_bank.sv
